// File: all.f
hdl/riscv_isa_pkg.sv
hdl/issue_pkg.sv
hdl/decode_if.sv
hdl/instruction_decoder.sv
hdl/register_scoreboard.sv
hdl/issue_control.sv
hdl/unit_operand_builder.sv
hdl/decode_issue_top.sv
sim/tb_decode_issue.sv

// File: hdl/decode_if.sv
////////////////////////////////////////
// Fields are combinational, valid with fb_valid
////////////////////////////////////////

interface decode_if;

    // Raw word, read through its I and S views
    riscv_isa_pkg::instr_word_u instr;

    // One-hot target unit, zero when illegal
    issue_pkg::unit_mask_t unit_req;

    // Register usage
    logic uses_rs1;
    logic uses_rs2;
    logic uses_rd;
    logic rd_zero;

    logic illegal;

    // ALU operand selects
    issue_pkg::alu_src1_e alu_src1;
    issue_pkg::alu_src2_e alu_src2;

    modport decoder (
        output instr, unit_req, uses_rs1, uses_rs2, uses_rd, rd_zero,
        output illegal, alu_src1, alu_src2
    );

    modport reader (
        input instr, unit_req, uses_rs1, uses_rs2, uses_rd, rd_zero,
        input illegal, alu_src1, alu_src2
    );

endinterface

// File: hdl/decode_issue_top.sv
////////////////////////////////////////
// Zero-cycle decode, register file read is external
////////////////////////////////////////

module decode_issue_top (
    input  logic                           clk,
    input  logic                           rst,

    // Fetch buffer
    input  logic                           fb_valid,
    input  logic [riscv_isa_pkg::xlen-1:0] fb_instruction,
    input  logic [riscv_isa_pkg::xlen-1:0] fb_pc,
    output logic                           fb_pop,

    // Register file read
    output issue_pkg::reg_addr_t           rs1_addr,
    output issue_pkg::reg_addr_t           rs2_addr,
    input  logic [riscv_isa_pkg::xlen-1:0] rs1_data,
    input  logic [riscv_isa_pkg::xlen-1:0] rs2_data,

    // Unit handshake and writeback
    input  issue_pkg::unit_mask_t          unit_ready,
    output issue_pkg::unit_mask_t          unit_issue,
    input  logic                           wb_valid,
    input  issue_pkg::reg_addr_t           wb_rd,
    output logic                           illegal,

    // Unit payloads
    output logic [riscv_isa_pkg::xlen-1:0] alu_in1,
    output logic [riscv_isa_pkg::xlen-1:0] alu_in2,
    output logic [2:0]                     alu_fn3,
    output logic                           alu_sub,
    output logic [riscv_isa_pkg::xlen-1:0] ls_addr,
    output logic [riscv_isa_pkg::xlen-1:0] ls_store_data,
    output logic                           ls_load,
    output logic                           ls_store,
    output logic [2:0]                     ls_fn3,
    output logic [riscv_isa_pkg::xlen-1:0] br_rs1,
    output logic [riscv_isa_pkg::xlen-1:0] br_rs2,
    output logic [2:0]                     br_fn3,
    output logic [riscv_isa_pkg::xlen-1:0] br_pc,
    output logic                           br_signed,
    output logic                           br_jal,
    output logic                           br_jalr
);

    logic                 rs1_conflict;
    logic                 rs2_conflict;
    logic                 set_valid;
    issue_pkg::reg_addr_t set_rd;

    decode_if dec_bus ();

    ////////////////////////////////////////
    // Decode, scoreboard, issue, operands
    instruction_decoder u_instruction_decoder (
        .dec            (dec_bus),
        .fb_instruction (fb_instruction),
        .rs1            (rs1_addr),
        .rs2            (rs2_addr)
    );

    register_scoreboard u_register_scoreboard (
        .clk          (clk),
        .rst          (rst),
        .rs1          (rs1_addr),
        .rs2          (rs2_addr),
        .set_valid    (set_valid),
        .set_rd       (set_rd),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .rs1_conflict (rs1_conflict),
        .rs2_conflict (rs2_conflict)
    );

    issue_control u_issue_control (
        .dec          (dec_bus),
        .fb_valid     (fb_valid),
        .unit_ready   (unit_ready),
        .rs1_conflict (rs1_conflict),
        .rs2_conflict (rs2_conflict),
        .unit_issue   (unit_issue),
        .fb_pop       (fb_pop),
        .illegal      (illegal),
        .set_valid    (set_valid),
        .set_rd       (set_rd)
    );

    unit_operand_builder u_unit_operand_builder (
        .dec           (dec_bus),
        .fb_pc         (fb_pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .alu_in1       (alu_in1),
        .alu_in2       (alu_in2),
        .alu_fn3       (alu_fn3),
        .alu_sub       (alu_sub),
        .ls_addr       (ls_addr),
        .ls_store_data (ls_store_data),
        .ls_load       (ls_load),
        .ls_store      (ls_store),
        .ls_fn3        (ls_fn3),
        .br_rs1        (br_rs1),
        .br_rs2        (br_rs2),
        .br_fn3        (br_fn3),
        .br_pc         (br_pc),
        .br_signed     (br_signed),
        .br_jal        (br_jal),
        .br_jalr       (br_jalr)
    );

endmodule

// File: hdl/instruction_decoder.sv
////////////////////////////////////////
// Purely combinational, OP with bit 25 (M ext) is illegal
////////////////////////////////////////

module instruction_decoder (
    decode_if.decoder                      dec,
    input  logic [riscv_isa_pkg::xlen-1:0] fb_instruction,
    output issue_pkg::reg_addr_t           rs1,
    output issue_pkg::reg_addr_t           rs2
);

    riscv_isa_pkg::instr_word_u word;

    assign word      = fb_instruction;
    assign dec.instr = word;

    // Register file read addresses
    assign rs1 = word.i.rs1;
    assign rs2 = word.s.rs2;

    assign dec.rd_zero = (word.i.rd == 5'd0);

    ////////////////////////////////////////
    // Unit selection and operand usage
    always_comb begin
        dec.unit_req = '0;
        dec.uses_rs1 = 1'b0;
        dec.uses_rs2 = 1'b0;
        dec.uses_rd  = 1'b0;
        dec.illegal  = 1'b0;
        dec.alu_src1 = issue_pkg::src1_rf;
        dec.alu_src2 = issue_pkg::src2_rf;

        case (word.i.opcode)
            riscv_isa_pkg::LUI: begin
                dec.unit_req[issue_pkg::unit_alu] = 1'b1;
                dec.uses_rd  = 1'b1;
                dec.alu_src1 = issue_pkg::src1_zero;
                dec.alu_src2 = issue_pkg::src2_imm_u;
            end
            riscv_isa_pkg::AUIPC: begin
                dec.unit_req[issue_pkg::unit_alu] = 1'b1;
                dec.uses_rd  = 1'b1;
                dec.alu_src1 = issue_pkg::src1_pc;
                dec.alu_src2 = issue_pkg::src2_imm_u;
            end
            riscv_isa_pkg::OP_IMM: begin
                dec.unit_req[issue_pkg::unit_alu] = 1'b1;
                dec.uses_rs1 = 1'b1;
                dec.uses_rd  = 1'b1;
                dec.alu_src2 = issue_pkg::src2_imm_i;
            end
            riscv_isa_pkg::OP: begin
                // Bit 25 marks MUL/DIV, not supported here
                if (word.s.imm_11_5[0]) begin
                    dec.illegal = 1'b1;
                end else begin
                    dec.unit_req[issue_pkg::unit_alu] = 1'b1;
                    dec.uses_rs1 = 1'b1;
                    dec.uses_rs2 = 1'b1;
                    dec.uses_rd  = 1'b1;
                end
            end
            // Link value pc + 4 is formed on the ALU operands
            riscv_isa_pkg::JAL: begin
                dec.unit_req[issue_pkg::unit_branch] = 1'b1;
                dec.uses_rd  = 1'b1;
                dec.alu_src1 = issue_pkg::src1_pc;
                dec.alu_src2 = issue_pkg::src2_four;
            end
            riscv_isa_pkg::JALR: begin
                dec.unit_req[issue_pkg::unit_branch] = 1'b1;
                dec.uses_rs1 = 1'b1;
                dec.uses_rd  = 1'b1;
                dec.alu_src1 = issue_pkg::src1_pc;
                dec.alu_src2 = issue_pkg::src2_four;
            end
            riscv_isa_pkg::BRANCH: begin
                dec.unit_req[issue_pkg::unit_branch] = 1'b1;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
            end
            riscv_isa_pkg::LOAD: begin
                dec.unit_req[issue_pkg::unit_ls] = 1'b1;
                dec.uses_rs1 = 1'b1;
                dec.uses_rd  = 1'b1;
            end
            riscv_isa_pkg::STORE: begin
                dec.unit_req[issue_pkg::unit_ls] = 1'b1;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
            end
            default: begin
                dec.illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: hdl/issue_control.sv
////////////////////////////////////////
// Single issue per cycle, stalls have no timeout
////////////////////////////////////////

module issue_control (
    decode_if.reader              dec,
    input  logic                  fb_valid,
    input  issue_pkg::unit_mask_t unit_ready,
    input  logic                  rs1_conflict,
    input  logic                  rs2_conflict,
    output issue_pkg::unit_mask_t unit_issue,
    output logic                  fb_pop,
    output logic                  illegal,
    output logic                  set_valid,
    output issue_pkg::reg_addr_t  set_rd
);

    logic operand_conflict;
    logic issue_allowed;
    logic issued;

    // Only sources the instruction actually reads can stall it
    assign operand_conflict = (dec.uses_rs1 & rs1_conflict)
                            | (dec.uses_rs2 & rs2_conflict);

    assign issue_allowed = fb_valid & ~dec.illegal & ~operand_conflict;

    ////////////////////////////////////////
    // Issue and pop
    assign unit_issue = {issue_pkg::num_units{issue_allowed}} & dec.unit_req & unit_ready;
    assign issued     = |unit_issue;

    // Illegal words are dropped from the buffer without issue
    assign illegal = fb_valid & dec.illegal;
    assign fb_pop  = issued | illegal;

    // Mark the destination busy once the instruction leaves
    assign set_valid = issued & dec.uses_rd & ~dec.rd_zero;
    assign set_rd    = dec.instr.i.rd;

endmodule

// File: hdl/issue_pkg.sv
////////////////////////////////////////
// Three execution units, fixed order in every unit mask
////////////////////////////////////////

package issue_pkg;

    ////////////////////////////////////////
    // Execution units

    // Bit position of each unit in a unit mask
    typedef enum logic [1:0] {
        unit_alu    = 2'd0,
        unit_ls     = 2'd1,
        unit_branch = 2'd2
    } unit_e;

    localparam int num_units = 3;

    // One bit per unit, indexed by unit_e
    typedef logic [num_units-1:0] unit_mask_t;

    ////////////////////////////////////////
    // ALU operand selects

    // First ALU operand
    typedef enum logic [1:0] {
        src1_rf   = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } alu_src1_e;

    // Second ALU operand
    typedef enum logic [1:0] {
        src2_rf    = 2'd0,
        src2_imm_i = 2'd1,
        src2_imm_u = 2'd2,
        src2_four  = 2'd3
    } alu_src2_e;

    // Architectural register address, x0 to x31
    typedef logic [4:0] reg_addr_t;

endpackage

// File: hdl/register_scoreboard.sv
////////////////////////////////////////
// x0 never busy, set wins over a same-cycle clear
////////////////////////////////////////

module register_scoreboard (
    input  logic                 clk,
    input  logic                 rst,
    input  issue_pkg::reg_addr_t rs1,
    input  issue_pkg::reg_addr_t rs2,
    input  logic                 set_valid,
    input  issue_pkg::reg_addr_t set_rd,
    input  logic                 wb_valid,
    input  issue_pkg::reg_addr_t wb_rd,
    output logic                 rs1_conflict,
    output logic                 rs2_conflict
);

    // One pending-write flag per architectural register
    logic [31:0] busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (wb_valid && (wb_rd != 5'd0)) begin
                busy[wb_rd] <= 1'b0;
            end
            // Later assignment, so a new owner overrides the writeback
            if (set_valid && (set_rd != 5'd0)) begin
                busy[set_rd] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Source lookups
    assign rs1_conflict = busy[rs1];
    assign rs2_conflict = busy[rs2];

endmodule

// File: hdl/riscv_isa_pkg.sv
////////////////////////////////////////
// RV32I base encodings only, no M, A or system opcodes
////////////////////////////////////////

package riscv_isa_pkg;

    // One machine word
    localparam int xlen = 32;

    ////////////////////////////////////////
    // Major opcodes
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_t;

    // Unsigned branch compares
    localparam logic [2:0] fn3_bltu = 3'b110;
    localparam logic [2:0] fn3_bgeu = 3'b111;

    ////////////////////////////////////////
    // Instruction word views

    // I format, also used for rd and the load offset
    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  fn3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } instr_i_t;

    // S format, source of rs2 and the store offset
    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] fn3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } instr_s_t;

    typedef union packed {
        instr_i_t i;
        instr_s_t s;
    } instr_word_u;

endpackage

// File: hdl/unit_operand_builder.sv
////////////////////////////////////////
// Outputs are payload, meaningful only in the issue cycle
////////////////////////////////////////

module unit_operand_builder (
    decode_if.reader                       dec,
    input  logic [riscv_isa_pkg::xlen-1:0] fb_pc,
    input  logic [riscv_isa_pkg::xlen-1:0] rs1_data,
    input  logic [riscv_isa_pkg::xlen-1:0] rs2_data,
    output logic [riscv_isa_pkg::xlen-1:0] alu_in1,
    output logic [riscv_isa_pkg::xlen-1:0] alu_in2,
    output logic [2:0]                     alu_fn3,
    output logic                           alu_sub,
    output logic [riscv_isa_pkg::xlen-1:0] ls_addr,
    output logic [riscv_isa_pkg::xlen-1:0] ls_store_data,
    output logic                           ls_load,
    output logic                           ls_store,
    output logic [2:0]                     ls_fn3,
    output logic [riscv_isa_pkg::xlen-1:0] br_rs1,
    output logic [riscv_isa_pkg::xlen-1:0] br_rs2,
    output logic [2:0]                     br_fn3,
    output logic [riscv_isa_pkg::xlen-1:0] br_pc,
    output logic                           br_signed,
    output logic                           br_jal,
    output logic                           br_jalr
);

    riscv_isa_pkg::opcode_t opcode;
    logic [2:0] fn3;
    logic [riscv_isa_pkg::xlen-1:0] imm_i;
    logic [riscv_isa_pkg::xlen-1:0] imm_u;
    logic [11:0] ls_offset;

    assign opcode = dec.instr.i.opcode;
    assign fn3    = dec.instr.i.fn3;

    // Sign-extended I immediate and upper U immediate
    assign imm_i = {{20{dec.instr.i.imm_11_0[11]}}, dec.instr.i.imm_11_0};
    assign imm_u = {dec.instr[31:12], 12'b0};

    ////////////////////////////////////////
    // ALU
    always_comb begin
        case (dec.alu_src1)
            issue_pkg::src1_zero: alu_in1 = '0;
            issue_pkg::src1_pc:   alu_in1 = fb_pc;
            default:              alu_in1 = rs1_data;
        endcase

        case (dec.alu_src2)
            issue_pkg::src2_imm_i: alu_in2 = imm_i;
            issue_pkg::src2_imm_u: alu_in2 = imm_u;
            issue_pkg::src2_four:  alu_in2 = 32'd4;
            default:               alu_in2 = rs2_data;
        endcase
    end

    assign alu_fn3 = fn3;
    // SUB and SRA share bit 30, only OP subtracts
    assign alu_sub = (opcode == riscv_isa_pkg::OP) & dec.instr.s.imm_11_5[5];

    ////////////////////////////////////////
    // Load/store
    assign ls_load  = (opcode == riscv_isa_pkg::LOAD);
    assign ls_store = (opcode == riscv_isa_pkg::STORE);

    assign ls_offset = ls_store ? {dec.instr.s.imm_11_5, dec.instr.s.imm_4_0}
                                : dec.instr.i.imm_11_0;

    assign ls_addr       = rs1_data + {{20{ls_offset[11]}}, ls_offset};
    assign ls_store_data = rs2_data;
    assign ls_fn3        = fn3;

    ////////////////////////////////////////
    // Branch
    assign br_rs1 = rs1_data;
    assign br_rs2 = rs2_data;
    assign br_fn3 = fn3;
    assign br_pc  = fb_pc;

    assign br_signed = !(fn3 inside {riscv_isa_pkg::fn3_bltu, riscv_isa_pkg::fn3_bgeu});

    // JAL has bit 3 set, JALR has bit 2 without bit 3
    assign br_jal  = opcode[3];
    assign br_jalr = ~opcode[3] & opcode[2];

endmodule

// File: sim/decode_issue_testdata.txt
# test valid instr pc rs1_data rs2_data ready wb_valid wb_rd (hex, test decimal)
# expected: issue pop illegal mask alu_in1 alu_in2 ls_addr (mask 1 alu, 2 ls)
1 1 00510093 00000100 00001000 00002000 7 0 00 1 1 0 1 00001000 00000005 00000000
1 1 00822183 00000104 00001000 00002000 7 0 00 2 1 0 2 00000000 00000000 00001008
1 1 00532623 00000108 00001000 00002000 7 0 00 2 1 0 2 00000000 00000000 0000100c
1 1 00838863 0000010c 00001000 00002000 7 0 00 4 1 0 0 00000000 00000000 00000000
2 1 123454b7 00000200 00001000 00002000 7 0 00 1 1 0 1 00000000 12345000 00000000
2 1 abcde517 00000204 00001000 00002000 7 0 00 1 1 0 1 00000204 abcde000 00000000
2 1 ffd60593 00000208 00001000 00002000 7 0 00 1 1 0 1 00001000 fffffffd 00000000
2 1 008006ef 0000020c 00001000 00002000 7 0 00 4 1 0 1 0000020c 00000004 00000000
3 1 ffc12703 00000300 00004000 00002000 7 0 00 2 1 0 2 00000000 00000000 00003ffc
3 1 fef12c23 00000304 00004000 00002000 7 0 00 2 1 0 2 00000000 00000000 00003ff8
3 1 02532223 00000308 00004000 00002000 7 0 00 2 1 0 2 00000000 00000000 00004024
4 1 013908b3 00000400 00001000 00002000 6 0 00 0 0 0 0 00000000 00000000 00000000
4 1 013908b3 00000400 00001000 00002000 6 0 00 0 0 0 0 00000000 00000000 00000000
4 1 013908b3 00000400 00001000 00002000 7 0 00 1 1 0 1 00001000 00002000 00000000
4 1 00012a03 00000404 00001000 00002000 5 0 00 0 0 0 0 00000000 00000000 00000000
4 1 00012a03 00000404 00001000 00002000 7 0 00 2 1 0 2 00000000 00000000 00001000
5 1 00100a93 00000500 00000000 00002000 7 0 00 1 1 0 1 00000000 00000001 00000000
5 1 002a8b13 00000504 00001000 00002000 7 0 00 0 0 0 0 00000000 00000000 00000000
5 1 002a8b13 00000504 00001000 00002000 7 1 15 0 0 0 0 00000000 00000000 00000000
5 1 002a8b13 00000504 00001000 00002000 7 0 00 1 1 0 1 00001000 00000002 00000000
5 1 01612023 00000508 00001000 00002000 7 0 00 0 0 0 0 00000000 00000000 00000000
5 1 01612023 00000508 00001000 00002000 7 1 16 0 0 0 0 00000000 00000000 00000000
5 1 01612023 00000508 00001000 00002000 7 0 00 2 1 0 2 00000000 00000000 00001000
6 0 039c0bb3 00000600 00001000 00002000 7 0 00 0 0 0 0 00000000 00000000 00000000
6 1 0000007f 00000600 00001000 00002000 7 0 00 0 1 1 0 00000000 00000000 00000000
6 1 039c0bb3 00000604 00001000 00002000 0 0 00 0 1 1 0 00000000 00000000 00000000
6 1 000b8d13 00000608 00001000 00002000 7 0 00 1 1 0 1 00001000 00000000 00000000

// File: sim/tb_decode_issue.sv
////////////////////////////////////////
// Vectors come from sim/decode_issue_testdata.txt, run from project root
// File payload columns are compared only where a vector's mask asks for it
////////////////////////////////////////

module tb_decode_issue;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_half   = 20;
    localparam int open_tries = 4;
    localparam int max_lines  = 500;
    localparam     data_path  = "sim/decode_issue_testdata.txt";

    // DUT inputs
    logic        clk;
    logic        rst;
    logic        fb_valid;
    logic [31:0] fb_instruction;
    logic [31:0] fb_pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [2:0]  unit_ready;
    logic        wb_valid;
    logic [4:0]  wb_rd;

    // DUT outputs
    logic        fb_pop;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [2:0]  unit_issue;
    logic        illegal;
    logic [31:0] alu_in1;
    logic [31:0] alu_in2;
    logic [2:0]  alu_fn3;
    logic        alu_sub;
    logic [31:0] ls_addr;
    logic [31:0] ls_store_data;
    logic        ls_load;
    logic        ls_store;
    logic [2:0]  ls_fn3;
    logic [31:0] br_rs1;
    logic [31:0] br_rs2;
    logic [2:0]  br_fn3;
    logic [31:0] br_pc;
    logic        br_signed;
    logic        br_jal;
    logic        br_jalr;

    // One vector as read from the file
    int          v_test;
    logic [31:0] v_valid;
    logic [31:0] v_instr;
    logic [31:0] v_pc;
    logic [31:0] v_rs1d;
    logic [31:0] v_rs2d;
    logic [31:0] v_ready;
    logic [31:0] v_wbv;
    logic [31:0] v_wbrd;
    logic [31:0] e_issue;
    logic [31:0] e_pop;
    logic [31:0] e_ill;
    logic [31:0] e_mask;
    logic [31:0] e_alu1;
    logic [31:0] e_alu2;
    logic [31:0] e_ls;

    // Bookkeeping
    int             fd;
    int             tries;
    int             fields;
    int             lines_read;
    int             vectors;
    int             cur_test;
    int             test_errors;
    int             test_cycles;
    int             tests_run;
    int             tests_failed;
    int             error_count;
    int             other_failures;
    reg [8*200-1:0] line_buf;

    decode_issue_top u_decode_issue_top (.*);

    always #(clk_half) clk = ~clk;

    ////////////////////////////////////////
    // Helpers

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h (file line %0d)",
                     $time, name, actual, expected, lines_read);
            error_count++;
            test_errors++;
        end
    endtask

    // Fields and pass-through payload taken from the RV32I encoding of the vector
    task automatic check_payload();
        logic [6:0] opcode;
        logic [2:0] fn3;
        opcode = v_instr[6:0];
        fn3    = v_instr[14:12];
        check_value("rs1_addr", rs1_addr, v_instr[19:15]);
        check_value("rs2_addr", rs2_addr, v_instr[24:20]);
        if (e_issue[0]) begin
            check_value("alu_fn3", alu_fn3, fn3);
            check_value("alu_sub", alu_sub, (opcode == 7'b0110011) && v_instr[30]);
        end
        if (e_issue[1]) begin
            check_value("ls_store_data", ls_store_data, v_rs2d);
            check_value("ls_load", ls_load, opcode == 7'b0000011);
            check_value("ls_store", ls_store, opcode == 7'b0100011);
            check_value("ls_fn3", ls_fn3, fn3);
        end
        if (e_issue[2]) begin
            check_value("br_rs1", br_rs1, v_rs1d);
            check_value("br_rs2", br_rs2, v_rs2d);
            check_value("br_fn3", br_fn3, fn3);
            check_value("br_pc", br_pc, v_pc);
            // BLTU and BGEU are the only unsigned compares
            check_value("br_signed", br_signed, fn3[2:1] != 2'b11);
            check_value("br_jal", br_jal, opcode == 7'b1101111);
            check_value("br_jalr", br_jalr, opcode == 7'b1100111);
        end
    endtask

    task automatic report_test();
        if (cur_test != 0) begin
            tests_run++;
            if (test_errors == 0) begin
                $display("Test %0d: passed in %0d cycles", cur_test, test_cycles);
            end else begin
                tests_failed++;
                $display("Test %0d: FAILED with %0d mismatches", cur_test, test_errors);
            end
        end
    endtask

    // Drive one vector at the edge, compare just before the next one
    task automatic run_vector();
        if (v_test != cur_test) begin
            report_test();
            cur_test    = v_test;
            test_errors = 0;
            test_cycles = 0;
        end
        @(posedge clk);
        fb_valid       <= v_valid[0];
        fb_instruction <= v_instr;
        fb_pc          <= v_pc;
        rs1_data       <= v_rs1d;
        rs2_data       <= v_rs2d;
        unit_ready     <= v_ready[2:0];
        wb_valid       <= v_wbv[0];
        wb_rd          <= v_wbrd[4:0];
        #(2 * clk_half - 2);
        test_cycles++;
        vectors++;
        check_value("unit_issue", unit_issue, e_issue);
        check_value("fb_pop", fb_pop, e_pop);
        check_value("illegal", illegal, e_ill);
        if (e_mask[0]) begin
            check_value("alu_in1", alu_in1, e_alu1);
            check_value("alu_in2", alu_in2, e_alu2);
        end
        if (e_mask[1]) begin
            check_value("ls_addr", ls_addr, e_ls);
        end
        check_payload();
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        fb_valid       = 1'b0;
        fb_instruction = '0;
        fb_pc          = '0;
        rs1_data       = '0;
        rs2_data       = '0;
        unit_ready     = '0;
        wb_valid       = 1'b0;
        wb_rd          = '0;
        fd             = 0;
        tries          = 0;
        lines_read     = 0;
        vectors        = 0;
        cur_test       = 0;
        test_errors    = 0;
        test_cycles    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        error_count    = 0;
        other_failures = 0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        while (fd == 0 && tries < open_tries) begin
            fd = $fopen(data_path, "r");
            tries++;
            if (fd == 0) begin
                @(posedge clk);
            end
        end

        if (fd == 0) begin
            $display("Could not open the stimulus file %s", data_path);
            other_failures++;
        end else begin
            // Comment and blank lines match no field and are skipped
            while (!$feof(fd) && lines_read < max_lines) begin
                lines_read++;
                if ($fgets(line_buf, fd) != 0) begin
                    fields = $sscanf(line_buf,
                        "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v_test, v_valid, v_instr, v_pc, v_rs1d, v_rs2d, v_ready,
                        v_wbv, v_wbrd, e_issue, e_pop, e_ill, e_mask, e_alu1,
                        e_alu2, e_ls);
                    if (fields == 16) begin
                        run_vector();
                    end else if (fields > 0) begin
                        $display("Stimulus line %0d is malformed, %0d fields read",
                                 lines_read, fields);
                        other_failures++;
                    end
                end
            end
            if (!$feof(fd)) begin
                $display("Timeout: stimulus file not finished after %0d lines", max_lines);
                other_failures++;
            end
            $fclose(fd);
        end

        if (vectors == 0) begin
            $display("No stimulus vectors were applied");
            other_failures++;
        end

        @(posedge clk);
        fb_valid <= 1'b0;
        report_test();
        $display("Summary: %0d tests, %0d failed, %0d mismatches, %0d other failures",
                 tests_run, tests_failed, error_count, other_failures);
        if (error_count == 0 && other_failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
